//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

   typedef logic [31:0] word_t;
   typedef logic [31:0] instr_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [6:0]  opcode_t;
   typedef logic [2:0]  funct3_t;
   typedef logic [6:0]  funct7_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B
   } alu_op_t;

   // Major opcodes of the supported subset
   localparam opcode_t OPC_OP     = 7'b0110011;
   localparam opcode_t OPC_OP_IMM = 7'b0010011;
   localparam opcode_t OPC_LUI    = 7'b0110111;
   localparam opcode_t OPC_LOAD   = 7'b0000011;
   localparam opcode_t OPC_STORE  = 7'b0100011;
   localparam opcode_t OPC_BRANCH = 7'b1100011;
   localparam opcode_t OPC_JAL    = 7'b1101111;
   localparam opcode_t OPC_SYSTEM = 7'b1110011;

   localparam funct3_t F3_ADD  = 3'b000;
   localparam funct3_t F3_SLT  = 3'b010;
   localparam funct3_t F3_XOR  = 3'b100;
   localparam funct3_t F3_OR   = 3'b110;
   localparam funct3_t F3_AND  = 3'b111;
   localparam funct3_t F3_BEQ  = 3'b000;
   localparam funct3_t F3_BNE  = 3'b001;
   // LW and SW share the word size code
   localparam funct3_t F3_WORD = 3'b010;

   localparam funct7_t F7_BASE = 7'b0000000;
   localparam funct7_t F7_SUB  = 7'b0100000;

endpackage

`default_nettype wire

//--- rtl/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

   // Operand source picked for the execute stage
   typedef enum logic [1:0] {
      FWD_RF,
      FWD_MEM,
      FWD_WB
   } fwd_sel_t;

   // Core run state around ECALL
   typedef enum logic [1:0] {
      RUN_ACTIVE,
      RUN_DRAIN,
      RUN_HALTED
   } run_state_t;

endpackage

`default_nettype wire

//--- rtl/pipe5_fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module pipe5_fetch_stage
   import rv_isa_pkg::*;
#(
   parameter word_t RESET_PC = 32'h0000_0000
) (
   input  logic   CLK,
   input  logic   rst,
   input  logic   stall,
   input  logic   flush,
   input  logic   run,
   input  logic   redirect,
   input  word_t  redirect_pc,
   input  instr_t imem_rdata,
   output word_t  imem_addr,
   output logic   fd_valid,
   output word_t  fd_pc,
   output instr_t fd_instr
);

   word_t pc;

   assign imem_addr = pc;

   always_ff @(posedge CLK) begin
      if (rst) begin
         pc <= RESET_PC;
      end else if (redirect) begin
         pc <= redirect_pc;
      end else if (!stall && run) begin
         pc <= pc + 32'd4;
      end
   end

   // Once run drops only bubbles leave fetch
   always_ff @(posedge CLK) begin
      if (rst || flush) begin
         fd_valid <= 1'b0;
      end else if (!stall) begin
         fd_valid <= run;
      end
   end

   always_ff @(posedge CLK) begin
      if (!stall) begin
         fd_pc    <= pc;
         fd_instr <= imem_rdata;
      end
   end

endmodule

`default_nettype wire

//--- rtl/pipe5_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module pipe5_decode_stage
   import rv_isa_pkg::*;
(
   input  logic     CLK,
   input  logic     rst,
   input  logic     stall,
   input  logic     flush,
   input  logic     fd_valid,
   input  word_t    fd_pc,
   input  instr_t   fd_instr,
   input  word_t    rs1_data,
   input  word_t    rs2_data,
   output reg_idx_t rs1,
   output reg_idx_t rs2,
   output logic     rs1_used,
   output logic     rs2_used,
   output logic     ecall_seen,
   output logic     de_valid,
   output reg_idx_t de_rd,
   output alu_op_t  de_alu_op,
   output logic     de_alu_imm,
   output word_t    de_imm,
   output word_t    de_rs1_data,
   output word_t    de_rs2_data,
   output word_t    de_pc,
   output logic     de_rd_write,
   output logic     de_load,
   output logic     de_store,
   output logic     de_beq,
   output logic     de_bne,
   output logic     de_jal,
   output logic     de_ecall
);

   opcode_t  opcode;
   funct3_t  funct3;
   funct7_t  funct7;
   reg_idx_t rd;
   word_t    imm_i;
   word_t    imm_s;
   word_t    imm_b;
   word_t    imm_j;
   word_t    imm_u;
   word_t    imm;
   alu_op_t  alu_op;
   logic     legal;
   logic     dec_valid;
   logic     use_rs1;
   logic     use_rs2;
   logic     alu_imm;
   logic     rd_write;
   logic     is_load;
   logic     is_store;
   logic     is_beq;
   logic     is_bne;
   logic     is_jal;
   logic     is_ecall;

   assign opcode = fd_instr[6:0];
   assign rd     = fd_instr[11:7];
   assign funct3 = fd_instr[14:12];
   assign rs1    = fd_instr[19:15];
   assign rs2    = fd_instr[24:20];
   assign funct7 = fd_instr[31:25];

   assign imm_i = {{20{fd_instr[31]}}, fd_instr[31:20]};
   assign imm_s = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
   assign imm_b = {{19{fd_instr[31]}}, fd_instr[31], fd_instr[7], fd_instr[30:25],
                   fd_instr[11:8], 1'b0};
   assign imm_j = {{11{fd_instr[31]}}, fd_instr[31], fd_instr[19:12], fd_instr[20],
                   fd_instr[30:21], 1'b0};
   assign imm_u = {fd_instr[31:12], 12'b0};

   always_comb begin
      legal    = 1'b1;
      use_rs1  = 1'b0;
      use_rs2  = 1'b0;
      alu_imm  = 1'b0;
      rd_write = 1'b0;
      is_load  = 1'b0;
      is_store = 1'b0;
      is_beq   = 1'b0;
      is_bne   = 1'b0;
      is_jal   = 1'b0;
      is_ecall = 1'b0;
      alu_op   = ALU_ADD;
      imm      = imm_i;
      case (opcode)
         OPC_OP, OPC_OP_IMM: begin
            use_rs1  = 1'b1;
            use_rs2  = (opcode == OPC_OP);
            alu_imm  = (opcode == OPC_OP_IMM);
            rd_write = 1'b1;
            case (funct3)
               F3_ADD:  alu_op = (opcode == OPC_OP && funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
               F3_SLT:  alu_op = ALU_SLT;
               F3_XOR:  alu_op = ALU_XOR;
               F3_OR:   alu_op = ALU_OR;
               F3_AND:  alu_op = ALU_AND;
               default: legal  = 1'b0;
            endcase
            if (opcode == OPC_OP && funct7 != F7_BASE && funct7 != F7_SUB) begin
               legal = 1'b0;
            end
         end
         OPC_LUI: begin
            alu_imm  = 1'b1;
            rd_write = 1'b1;
            alu_op   = ALU_PASS_B;
            imm      = imm_u;
         end
         OPC_LOAD: begin
            use_rs1  = 1'b1;
            alu_imm  = 1'b1;
            rd_write = 1'b1;
            is_load  = 1'b1;
            legal    = (funct3 == F3_WORD);
         end
         OPC_STORE: begin
            use_rs1  = 1'b1;
            use_rs2  = 1'b1;
            alu_imm  = 1'b1;
            is_store = 1'b1;
            imm      = imm_s;
            legal    = (funct3 == F3_WORD);
         end
         OPC_BRANCH: begin
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
            imm     = imm_b;
            is_beq  = (funct3 == F3_BEQ);
            is_bne  = (funct3 == F3_BNE);
            legal   = is_beq || is_bne;
         end
         OPC_JAL: begin
            rd_write = 1'b1;
            is_jal   = 1'b1;
            imm      = imm_j;
         end
         OPC_SYSTEM: is_ecall = 1'b1;
         default:    legal    = 1'b0;
      endcase
      // x0 is never a destination
      if (rd == '0) begin
         rd_write = 1'b0;
      end
   end

   // Unknown encodings simply become bubbles
   assign dec_valid  = fd_valid && legal;
   assign rs1_used   = dec_valid && use_rs1;
   assign rs2_used   = dec_valid && use_rs2;
   assign ecall_seen = dec_valid && is_ecall;

   always_ff @(posedge CLK) begin
      if (rst || stall || flush) begin
         de_valid    <= 1'b0;
         de_rd_write <= 1'b0;
         de_load     <= 1'b0;
         de_store    <= 1'b0;
         de_beq      <= 1'b0;
         de_bne      <= 1'b0;
         de_jal      <= 1'b0;
         de_ecall    <= 1'b0;
      end else begin
         de_valid    <= dec_valid;
         de_rd_write <= dec_valid && rd_write;
         de_load     <= dec_valid && is_load;
         de_store    <= dec_valid && is_store;
         de_beq      <= dec_valid && is_beq;
         de_bne      <= dec_valid && is_bne;
         de_jal      <= dec_valid && is_jal;
         de_ecall    <= dec_valid && is_ecall;
      end
   end

   always_ff @(posedge CLK) begin
      de_rd       <= rd;
      de_alu_op   <= alu_op;
      de_alu_imm  <= alu_imm;
      de_imm      <= imm;
      de_rs1_data <= rs1_data;
      de_rs2_data <= rs2_data;
      de_pc       <= fd_pc;
   end

endmodule

`default_nettype wire

//--- rtl/rv32i_reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module rv32i_reg_file
   import rv_isa_pkg::*;
(
   input  logic     CLK,
   input  logic     rst,
   input  reg_idx_t rs1,
   input  reg_idx_t rs2,
   input  logic     we,
   input  reg_idx_t wr_idx,
   input  word_t    wr_data,
   output word_t    rs1_data,
   output word_t    rs2_data
);

   // x0 has no storage
   word_t regs [1:31];

   // Same-cycle write is visible to the reader
   function automatic word_t read_port(input reg_idx_t idx);
      if (idx == '0) begin
         return '0;
      end else if (we && wr_idx == idx) begin
         return wr_data;
      end
      return regs[idx];
   endfunction

   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && wr_idx != '0) begin
         regs[wr_idx] <= wr_data;
      end
   end

   always_comb begin
      rs1_data = read_port(rs1);
      rs2_data = read_port(rs2);
   end

endmodule

`default_nettype wire

//--- rtl/pipe5_execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module pipe5_execute_stage
   import rv_isa_pkg::*;
   import pipe_ctrl_pkg::*;
(
   input  logic     CLK,
   input  logic     rst,
   input  logic     de_valid,
   input  reg_idx_t de_rd,
   input  alu_op_t  de_alu_op,
   input  logic     de_alu_imm,
   input  word_t    de_imm,
   input  word_t    de_rs1_data,
   input  word_t    de_rs2_data,
   input  word_t    de_pc,
   input  logic     de_rd_write,
   input  logic     de_load,
   input  logic     de_store,
   input  logic     de_beq,
   input  logic     de_bne,
   input  logic     de_jal,
   input  logic     de_ecall,
   input  fwd_sel_t fwd_a,
   input  fwd_sel_t fwd_b,
   input  word_t    mem_fwd_data,
   input  word_t    wb_fwd_data,
   output logic     em_valid,
   output reg_idx_t em_rd,
   output word_t    em_result,
   output word_t    em_store_data,
   output word_t    em_pc,
   output logic     em_rd_write,
   output logic     em_load,
   output logic     em_store,
   output logic     em_ecall,
   output logic     redirect,
   output word_t    redirect_pc
);

   word_t op_a;
   word_t op_b;
   word_t alu_b;
   word_t alu_out;
   word_t result;

   function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf_val);
      case (sel)
         FWD_MEM: return mem_fwd_data;
         FWD_WB:  return wb_fwd_data;
         default: return rf_val;
      endcase
   endfunction

   always_comb begin
      op_a = fwd_mux(fwd_a, de_rs1_data);
      op_b = fwd_mux(fwd_b, de_rs2_data);
   end

   assign alu_b = de_alu_imm ? de_imm : op_b;

   always_comb begin
      case (de_alu_op)
         ALU_SUB:    alu_out = op_a - alu_b;
         ALU_AND:    alu_out = op_a & alu_b;
         ALU_OR:     alu_out = op_a | alu_b;
         ALU_XOR:    alu_out = op_a ^ alu_b;
         ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
         ALU_PASS_B: alu_out = alu_b;
         default:    alu_out = op_a + alu_b;
      endcase
   end

   // JAL links pc+4, branch and jump targets share one adder
   assign result      = de_jal ? de_pc + 32'd4 : alu_out;
   assign redirect_pc = de_pc + de_imm;
   assign redirect    = de_valid && (de_jal || (de_beq && op_a == op_b) ||
                                     (de_bne && op_a != op_b));

   always_ff @(posedge CLK) begin
      if (rst) begin
         em_valid    <= 1'b0;
         em_rd_write <= 1'b0;
         em_load     <= 1'b0;
         em_store    <= 1'b0;
         em_ecall    <= 1'b0;
      end else begin
         em_valid    <= de_valid;
         em_rd_write <= de_rd_write;
         em_load     <= de_load;
         em_store    <= de_store;
         em_ecall    <= de_ecall;
      end
   end

   always_ff @(posedge CLK) begin
      em_rd         <= de_rd;
      em_result     <= result;
      em_store_data <= op_b;
      em_pc         <= de_pc;
   end

endmodule

`default_nettype wire

//--- rtl/pipe5_mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module pipe5_mem_stage
   import rv_isa_pkg::*;
#(
   parameter int DMEM_WORDS = 64
) (
   input  logic     CLK,
   input  logic     rst,
   input  logic     em_valid,
   input  reg_idx_t em_rd,
   input  word_t    em_result,
   input  word_t    em_store_data,
   input  word_t    em_pc,
   input  logic     em_rd_write,
   input  logic     em_load,
   input  logic     em_store,
   input  logic     em_ecall,
   output reg_idx_t mw_rd,
   output word_t    mw_wb_data,
   output word_t    mw_pc,
   output logic     mw_rd_write,
   output logic     mw_ecall,
   output word_t    mem_fwd_data,
   output logic     retire_valid
);

   // Depth is taken as a power of two, so the slice wraps modulo depth
   localparam int AW = $clog2(DMEM_WORDS);

   word_t          dmem [DMEM_WORDS];
   logic [AW-1:0]  dmem_idx;
   logic           mw_valid;

   assign dmem_idx = em_result[AW+1:2];

   always_ff @(posedge CLK) begin
      if (em_valid && em_store) begin
         dmem[dmem_idx] <= em_store_data;
      end
   end

   // Value this instruction will write back
   assign mem_fwd_data = em_load ? dmem[dmem_idx] : em_result;

   always_ff @(posedge CLK) begin
      if (rst) begin
         mw_valid    <= 1'b0;
         mw_rd_write <= 1'b0;
         mw_ecall    <= 1'b0;
      end else begin
         mw_valid    <= em_valid;
         mw_rd_write <= em_rd_write;
         mw_ecall    <= em_valid && em_ecall;
      end
   end

   always_ff @(posedge CLK) begin
      mw_rd      <= em_rd;
      mw_wb_data <= mem_fwd_data;
      mw_pc      <= em_pc;
   end

   assign retire_valid = mw_valid && mw_rd_write;

endmodule

`default_nettype wire

//--- rtl/pipe5_hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module pipe5_hazard_unit
   import rv_isa_pkg::*;
   import pipe_ctrl_pkg::*;
(
   input  logic     CLK,
   input  logic     rst,
   input  reg_idx_t rs1,
   input  reg_idx_t rs2,
   input  logic     rs1_used,
   input  logic     rs2_used,
   input  reg_idx_t de_rd,
   input  logic     de_load,
   input  logic     de_rd_write,
   input  reg_idx_t em_rd,
   input  logic     em_rd_write,
   input  reg_idx_t mw_rd,
   input  logic     mw_rd_write,
   input  logic     redirect,
   input  logic     ecall_seen,
   input  logic     mw_ecall,
   input  word_t    mw_pc,
   output fwd_sel_t fwd_a,
   output fwd_sel_t fwd_b,
   output logic     stall,
   output logic     flush,
   output logic     run,
   output logic     halt,
   output word_t    halt_pc
);

   run_state_t state;
   reg_idx_t   ex_rs1;
   reg_idx_t   ex_rs2;
   logic       ex_rs1_used;
   logic       ex_rs2_used;
   logic       ecall_enter;

   // Sources of the instruction now in execute, mirrored from decode
   always_ff @(posedge CLK) begin
      if (rst) begin
         ex_rs1_used <= 1'b0;
         ex_rs2_used <= 1'b0;
      end else begin
         ex_rs1_used <= rs1_used && !stall && !flush;
         ex_rs2_used <= rs2_used && !stall && !flush;
      end
      ex_rs1 <= rs1;
      ex_rs2 <= rs2;
   end

   // Memory stage wins over writeback
   function automatic fwd_sel_t pick_src(input reg_idx_t src, input logic used);
      if (!used || src == '0) begin
         return FWD_RF;
      end else if (em_rd_write && em_rd == src) begin
         return FWD_MEM;
      end else if (mw_rd_write && mw_rd == src) begin
         return FWD_WB;
      end
      return FWD_RF;
   endfunction

   always_comb begin
      fwd_a = pick_src(ex_rs1, ex_rs1_used);
      fwd_b = pick_src(ex_rs2, ex_rs2_used);
   end

   assign stall = de_load && de_rd_write &&
                  ((rs1_used && rs1 == de_rd) || (rs2_used && rs2 == de_rd));
   assign flush = redirect;

   // An ECALL on a squashed path must not stop the core
   assign ecall_enter = ecall_seen && !flush;

   always_ff @(posedge CLK) begin
      if (rst) begin
         state <= RUN_ACTIVE;
      end else begin
         case (state)
            RUN_ACTIVE: if (ecall_enter) state <= RUN_DRAIN;
            RUN_DRAIN:  if (mw_ecall) state <= RUN_HALTED;
            default:    state <= RUN_HALTED;
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (state == RUN_DRAIN && mw_ecall) begin
         halt_pc <= mw_pc;
      end
   end

   assign run  = (state == RUN_ACTIVE) && !ecall_enter;
   assign halt = (state == RUN_HALTED);

endmodule

`default_nettype wire

//--- rtl/pipe5.sv
`timescale 1ns/10ps
`default_nettype none

module pipe5
   import rv_isa_pkg::*;
   import pipe_ctrl_pkg::*;
#(
   parameter word_t RESET_PC   = 32'h0000_0000,
   parameter int    DMEM_WORDS = 64
) (
   input  logic     CLK,
   input  logic     rst,
   input  instr_t   imem_rdata,
   output word_t    imem_addr,
   output logic     retire_valid,
   output reg_idx_t retire_rd,
   output word_t    retire_data,
   output logic     halt,
   output word_t    halt_pc
);

   logic     stall;
   logic     flush;
   logic     run;
   logic     redirect;
   word_t    redirect_pc;
   logic     fd_valid;
   word_t    fd_pc;
   instr_t   fd_instr;
   reg_idx_t rs1;
   reg_idx_t rs2;
   logic     rs1_used;
   logic     rs2_used;
   word_t    rs1_data;
   word_t    rs2_data;
   logic     ecall_seen;
   logic     de_valid;
   reg_idx_t de_rd;
   alu_op_t  de_alu_op;
   logic     de_alu_imm;
   word_t    de_imm;
   word_t    de_rs1_data;
   word_t    de_rs2_data;
   word_t    de_pc;
   logic     de_rd_write;
   logic     de_load;
   logic     de_store;
   logic     de_beq;
   logic     de_bne;
   logic     de_jal;
   logic     de_ecall;
   fwd_sel_t fwd_a;
   fwd_sel_t fwd_b;
   logic     em_valid;
   reg_idx_t em_rd;
   word_t    em_result;
   word_t    em_store_data;
   word_t    em_pc;
   logic     em_rd_write;
   logic     em_load;
   logic     em_store;
   logic     em_ecall;
   word_t    mem_fwd_data;
   word_t    mw_pc;
   logic     mw_rd_write;
   logic     mw_ecall;

   pipe5_fetch_stage #(
      .RESET_PC(RESET_PC)
   ) fetch_stage (
       .CLK(CLK)
      ,.rst(rst)
      ,.stall(stall)
      ,.flush(flush)
      ,.run(run)
      ,.redirect(redirect)
      ,.redirect_pc(redirect_pc)
      ,.imem_rdata(imem_rdata)
      ,.imem_addr(imem_addr)
      ,.fd_valid(fd_valid)
      ,.fd_pc(fd_pc)
      ,.fd_instr(fd_instr)
   );

   pipe5_decode_stage decode_stage (
       .CLK(CLK)
      ,.rst(rst)
      ,.stall(stall)
      ,.flush(flush)
      ,.fd_valid(fd_valid)
      ,.fd_pc(fd_pc)
      ,.fd_instr(fd_instr)
      ,.rs1_data(rs1_data)
      ,.rs2_data(rs2_data)
      ,.rs1(rs1)
      ,.rs2(rs2)
      ,.rs1_used(rs1_used)
      ,.rs2_used(rs2_used)
      ,.ecall_seen(ecall_seen)
      ,.de_valid(de_valid)
      ,.de_rd(de_rd)
      ,.de_alu_op(de_alu_op)
      ,.de_alu_imm(de_alu_imm)
      ,.de_imm(de_imm)
      ,.de_rs1_data(de_rs1_data)
      ,.de_rs2_data(de_rs2_data)
      ,.de_pc(de_pc)
      ,.de_rd_write(de_rd_write)
      ,.de_load(de_load)
      ,.de_store(de_store)
      ,.de_beq(de_beq)
      ,.de_bne(de_bne)
      ,.de_jal(de_jal)
      ,.de_ecall(de_ecall)
   );

   // Written straight from the writeback register
   rv32i_reg_file rg_file (
       .CLK(CLK)
      ,.rst(rst)
      ,.rs1(rs1)
      ,.rs2(rs2)
      ,.we(retire_valid)
      ,.wr_idx(retire_rd)
      ,.wr_data(retire_data)
      ,.rs1_data(rs1_data)
      ,.rs2_data(rs2_data)
   );

   pipe5_execute_stage execute_stage (
       .CLK(CLK)
      ,.rst(rst)
      ,.de_valid(de_valid)
      ,.de_rd(de_rd)
      ,.de_alu_op(de_alu_op)
      ,.de_alu_imm(de_alu_imm)
      ,.de_imm(de_imm)
      ,.de_rs1_data(de_rs1_data)
      ,.de_rs2_data(de_rs2_data)
      ,.de_pc(de_pc)
      ,.de_rd_write(de_rd_write)
      ,.de_load(de_load)
      ,.de_store(de_store)
      ,.de_beq(de_beq)
      ,.de_bne(de_bne)
      ,.de_jal(de_jal)
      ,.de_ecall(de_ecall)
      ,.fwd_a(fwd_a)
      ,.fwd_b(fwd_b)
      ,.mem_fwd_data(mem_fwd_data)
      ,.wb_fwd_data(retire_data)
      ,.em_valid(em_valid)
      ,.em_rd(em_rd)
      ,.em_result(em_result)
      ,.em_store_data(em_store_data)
      ,.em_pc(em_pc)
      ,.em_rd_write(em_rd_write)
      ,.em_load(em_load)
      ,.em_store(em_store)
      ,.em_ecall(em_ecall)
      ,.redirect(redirect)
      ,.redirect_pc(redirect_pc)
   );

   pipe5_mem_stage #(
      .DMEM_WORDS(DMEM_WORDS)
   ) mem_stage (
       .CLK(CLK)
      ,.rst(rst)
      ,.em_valid(em_valid)
      ,.em_rd(em_rd)
      ,.em_result(em_result)
      ,.em_store_data(em_store_data)
      ,.em_pc(em_pc)
      ,.em_rd_write(em_rd_write)
      ,.em_load(em_load)
      ,.em_store(em_store)
      ,.em_ecall(em_ecall)
      ,.mw_rd(retire_rd)
      ,.mw_wb_data(retire_data)
      ,.mw_pc(mw_pc)
      ,.mw_rd_write(mw_rd_write)
      ,.mw_ecall(mw_ecall)
      ,.mem_fwd_data(mem_fwd_data)
      ,.retire_valid(retire_valid)
   );

   pipe5_hazard_unit hazard_unit (
       .CLK(CLK)
      ,.rst(rst)
      ,.rs1(rs1)
      ,.rs2(rs2)
      ,.rs1_used(rs1_used)
      ,.rs2_used(rs2_used)
      ,.de_rd(de_rd)
      ,.de_load(de_load)
      ,.de_rd_write(de_rd_write)
      ,.em_rd(em_rd)
      ,.em_rd_write(em_rd_write)
      ,.mw_rd(retire_rd)
      ,.mw_rd_write(mw_rd_write)
      ,.redirect(redirect)
      ,.ecall_seen(ecall_seen)
      ,.mw_ecall(mw_ecall)
      ,.mw_pc(mw_pc)
      ,.fwd_a(fwd_a)
      ,.fwd_b(fwd_b)
      ,.stall(stall)
      ,.flush(flush)
      ,.run(run)
      ,.halt(halt)
      ,.halt_pc(halt_pc)
   );

endmodule

`default_nettype wire

//--- testbench/pipe5_checker.sv
`timescale 1ns/10ps
`default_nettype none

module pipe5_checker
   import rv_isa_pkg::*;
(
   input logic     CLK,
   input logic     rst,
   input logic     retire_valid,
   input reg_idx_t retire_rd,
   input logic     halt,
   input word_t    halt_pc,
   input word_t    imem_addr,
   input logic     stall,
   input logic     flush,
   input logic     redirect
);

   a_no_x0_retire: assert property (@(posedge CLK) disable iff (rst)
      retire_valid |-> retire_rd != '0)
      else $error("retire with rd zero");

   a_halt_sticky: assert property (@(posedge CLK) disable iff (rst)
      halt |=> halt)
      else $error("halt fell after rising");

   a_halt_pc_stable: assert property (@(posedge CLK) disable iff (rst)
      halt |=> $stable(halt_pc))
      else $error("halt pc changed while halted");

   a_no_retire_halted: assert property (@(posedge CLK) disable iff (rst)
      halt |-> !retire_valid)
      else $error("retire after halt");

   // A load-use stall never meets a squash
   a_stall_no_flush: assert property (@(posedge CLK) disable iff (rst)
      stall |-> !(flush || redirect))
      else $error("flush during load-use stall");

   a_pc_aligned: assert property (@(posedge CLK) disable iff (rst)
      imem_addr[1:0] == 2'b00)
      else $error("fetch address not word aligned");

endmodule

bind pipe5 pipe5_checker checker_inst (
    .CLK(CLK)
   ,.rst(rst)
   ,.retire_valid(retire_valid)
   ,.retire_rd(retire_rd)
   ,.halt(halt)
   ,.halt_pc(halt_pc)
   ,.imem_addr(imem_addr)
   ,.stall(stall)
   ,.flush(flush)
   ,.redirect(redirect)
);

`default_nettype wire

//--- testbench/pipe5_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pipe5_clk_gen (
   output logic CLK
);

   initial begin
      CLK = 1'b0;
      forever #20 CLK = ~CLK;
   end

endmodule

module pipe5_tb
   import rv_isa_pkg::*;
;

   localparam instr_t NOP_WORD      = 32'h0000_0013;
   localparam int     HALT_TIMEOUT  = 2000;
   localparam int     GOLDEN_WORDS  = 128;

   logic     CLK;
   logic     rst;
   instr_t   imem_rdata;
   word_t    imem_addr;
   logic     retire_valid;
   reg_idx_t retire_rd;
   word_t    retire_data;
   logic     halt;
   word_t    halt_pc;

   word_t golden [GOLDEN_WORDS];
   int    prog_len;
   int    exp_cnt;
   int    ret_idx;
   int    test_err [1:5];
   int    halt_errs;
   int    failed_tests;
   int    cycles;
   bit    ok;
   string test_name [1:5];

   pipe5_clk_gen clk_gen (
      .CLK(CLK)
   );

   pipe5 i_dut (
       .CLK(CLK)
      ,.rst(rst)
      ,.imem_rdata(imem_rdata)
      ,.imem_addr(imem_addr)
      ,.retire_valid(retire_valid)
      ,.retire_rd(retire_rd)
      ,.retire_data(retire_data)
      ,.halt(halt)
      ,.halt_pc(halt_pc)
   );

   // Words past the program read as NOP
   function automatic instr_t fetch_word(input word_t addr);
      int idx;
      idx = int'(addr >> 2);
      if (addr[1:0] == 2'b00 && idx < prog_len) begin
         return golden[1 + idx];
      end
      return NOP_WORD;
   endfunction

   task automatic check(input word_t got, input word_t exp, input string msg, output bit pass);
      pass = (got === exp);
      if (!pass) begin
         $display("mismatch @ %0t: %s got %h expected %h", $time, msg, got, exp);
      end
   endtask

   // Instruction memory answers from the address held since the last rising edge
   always @(negedge CLK) begin
      imem_rdata <= fetch_word(imem_addr);
   end

   // Retirements compared in program order
   always @(negedge CLK) begin
      int  base;
      int  grp;
      bit  rd_ok;
      bit  val_ok;
      if (!rst && retire_valid) begin
         base = 2 + prog_len + 3 * ret_idx;
         if (halt) begin
            $display("retirement of x%0d seen after halt at %0t", retire_rd, $time);
            test_err[5]++;
         end else if (retire_rd == '0) begin
            $display("a write to x0 retired at %0t", $time);
            test_err[4]++;
         end else if (ret_idx >= exp_cnt) begin
            $display("unexpected extra retirement of x%0d at %0t", retire_rd, $time);
            test_err[5]++;
         end else begin
            grp = int'(golden[base]);
            check({27'b0, retire_rd}, golden[base + 1], "retire rd", rd_ok);
            check(retire_data, golden[base + 2], "retire data", val_ok);
            if (!(rd_ok && val_ok)) begin
               test_err[grp]++;
            end
         end
         ret_idx++;
      end
   end

   initial begin
      rst          = 1'b1;
      imem_rdata   = NOP_WORD;
      ret_idx      = 0;
      halt_errs    = 0;
      failed_tests = 0;
      for (int i = 1; i <= 5; i++) begin
         test_err[i] = 0;
      end
      test_name[1] = "alu and immediate forwarding";
      test_name[2] = "load-use";
      test_name[3] = "branch and jump flushes";
      test_name[4] = "x0 writes";
      test_name[5] = "halt";
      $readmemh("testbench/pipe5_golden.hex", golden);
      prog_len = int'(golden[0]);
      exp_cnt  = int'(golden[1 + prog_len]);

      repeat (5) @(negedge CLK);
      rst = 1'b0;

      cycles = 0;
      while (!halt && cycles < HALT_TIMEOUT) begin
         @(negedge CLK);
         cycles++;
      end
      if (!halt) begin
         $display("timeout: halt did not rise within %0d cycles", HALT_TIMEOUT);
         halt_errs++;
      end else begin
         check(halt_pc, golden[2 + prog_len + 3 * exp_cnt], "halt pc", ok);
         if (!ok) begin
            halt_errs++;
         end
         // A few more cycles to catch late retirements
         repeat (5) @(negedge CLK);
         check(word_t'(ret_idx), word_t'(exp_cnt), "retire count", ok);
         if (!ok) begin
            halt_errs++;
         end
         if (!halt) begin
            $display("halt dropped again at %0t after it had risen", $time);
            halt_errs++;
         end
      end

      for (int i = 1; i <= 5; i++) begin
         if (i == 5) begin
            test_err[5] += halt_errs;
         end
         if (test_err[i] == 0) begin
            $display("test %0d %s: PASS", i, test_name[i]);
         end else begin
            $display("test %0d %s: FAIL (%0d errors)", i, test_name[i], test_err[i]);
            failed_tests++;
         end
      end
      $display("tests run 5, passed %0d, failed %0d", 5 - failed_tests, failed_tests);
      if (failed_tests == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/pipe5_golden.hex
// program word count, then the program words from address 0
// retire count, then (test group, rd, value) triples in order, then the halt pc
0000001a
00500093 00308113 002081b3 40118233 0ff24293 0020a333 123453b7 0033e433
005474b3 00802423 00802503 001505b3 00708013 00100633 00208463 00209663
00100693 00200693 00c0076f 00100793 00200793 00160463 00900813 00170893
00000073 00100913
0000000e
00000001 00000001 00000005
00000001 00000002 00000008
00000001 00000003 0000000d
00000001 00000004 00000008
00000001 00000005 000000f7
00000001 00000006 00000001
00000001 00000007 12345000
00000001 00000008 1234500d
00000001 00000009 00000005
00000002 0000000a 1234500d
00000002 0000000b 12345012
00000004 0000000c 00000005
00000003 0000000e 0000004c
00000003 00000011 0000004d
00000060

//--- build.f
rtl/rv_isa_pkg.sv
rtl/pipe_ctrl_pkg.sv
rtl/pipe5_fetch_stage.sv
rtl/pipe5_decode_stage.sv
rtl/rv32i_reg_file.sv
rtl/pipe5_execute_stage.sv
rtl/pipe5_mem_stage.sv
rtl/pipe5_hazard_unit.sv
rtl/pipe5.sv
testbench/pipe5_checker.sv
testbench/pipe5_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module pipe5_tb -o pipe5_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi
out=$(./obj_dir/pipe5_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi
if echo "$out" | grep -q "All tests passed!"; then
   exit 0
fi
exit 1
